// File: bench/mac_rx_stim.txt
# frame dst src ethertype payload_len payload_bytes... bad_fcs runt expected_status
# expected_status is {fcs_ok, runt, accepted} in hex; totals gives good fcs_err filtered
frame 020000000001 0a1b2c3d4e5f 0800 8
  11 22 33 44 55 66 77 88
  0 0 5
frame ffffffffffff 0a1b2c3d4e60 0806 6
  de ad be ef 00 01
  0 0 5
frame 020000000099 0a1b2c3d4e61 0800 5
  a0 a1 a2 a3 a4
  0 0 4
frame 020000000001 0a1b2c3d4e62 86dd 7
  55 d5 55 d5 00 ff 7e
  1 0 1
frame 020000000001 0a1b2c3d4e63 0800 6
  01 02 03 04 05 06
  0 1 2
frame 020000000001 0a1b2c3d4e64 0800 1
  c3
  0 0 5
frame ffffffffffff 0a1b2c3d4e65 88b5 4
  10 20 30 40
  1 0 1
frame 020000000001 0a1b2c3d4e66 0800 10
  00 11 22 33 44 55 66 77 88 99
  0 0 5
totals 4 2 2

// File: build.f
hw/mac_rx_pkg.sv
hw/crc32.sv
hw/mac_rx.sv
hw/mac_addr_filter.sv
hw/mac_rx_top.sv
bench/mac_rx_assertions.sv
bench/mac_rx_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mac_rx_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  ?= build.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/mac_rx_tb.sv
module mac_rx_tb;

  import mac_rx_pkg::*;

  localparam mac_addr_t STATION    = 48'h02_00_00_00_00_01;
  localparam int        MAX_FRAMES = 16;
  localparam int        MAX_BYTES  = 512;
  localparam int        RUNT_KEEP  = 10; // bytes after sfd in a truncated frame
  localparam int        MIN_GAP    = 4;  // shortest idle time between frames

  logic       clk;
  logic       fsm_rst;
  logic [7:0] phy_dat;
  logic       phy_val;
  rx_strm_t   out_strm;
  mac_hdr_t   out_hdr;
  logic       out_hdr_val;
  logic       frame_done;
  rx_status_t frame_status;
  rx_cnt_t    cnt_good;
  rx_cnt_t    cnt_fcs_err;
  rx_cnt_t    cnt_filtered;

  integer seed;
  int     errors;
  int     cycles;
  int     cycle_limit;
  int     done_seen;
  int     n_frames;
  bit     stim_ok;

  // frame table from the stim file
  logic [47:0] f_dst  [MAX_FRAMES];
  logic [47:0] f_src  [MAX_FRAMES];
  logic [15:0] f_type [MAX_FRAMES];
  int          f_len  [MAX_FRAMES];
  int          f_base [MAX_FRAMES];
  int          f_gap  [MAX_FRAMES];
  bit          f_bad  [MAX_FRAMES];
  bit          f_runt [MAX_FRAMES];
  logic [2:0]  f_exp  [MAX_FRAMES];
  logic [7:0]  pay_mem [MAX_BYTES];
  int          tot_good;
  int          tot_fcs;
  int          tot_filt;

  // scoreboard
  logic [17:0] exp_bytes [$]; // frame index, sof, eof, data
  mac_hdr_t    exp_hdrs  [$];
  rx_status_t  exp_stats [$];
  int          tally_good;
  int          tally_fcs;
  int          tally_filt;
  logic [17:0] exp_b;

  mac_rx_top #(
    .MAC_ADDR (STATION),
    .PROMISC  (1'b0)
  ) u_mac_rx_top (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .phy_dat      (phy_dat),
    .phy_val      (phy_val),
    .out_strm     (out_strm),
    .out_hdr      (out_hdr),
    .out_hdr_val  (out_hdr_val),
    .frame_done   (frame_done),
    .frame_status (frame_status),
    .cnt_good     (cnt_good),
    .cnt_fcs_err  (cnt_fcs_err),
    .cnt_filtered (cnt_filtered)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d of %0d frames finished", cycles, done_seen,
               n_frames);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [111:0] exp, input logic [111:0] got);
    assert (exp === got) else begin
      errors++;
      $display("FAIL %s expected %0h actual %0h", name, exp, got);
    end
  endtask

  // reflected ieee crc with the lsb of each octet first
  function automatic logic [31:0] fcs_step(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c ^ {24'h0, d};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
    end
    return r;
  endfunction

  task automatic read_stim(output bit ok);
    int                fd;
    int                r;
    int                nb;
    logic [8*16-1:0]   tok;
    logic [8*200-1:0]  rest;
    ok = 1'b0;
    nb = 0;
    fd = $fopen("bench/mac_rx_stim.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        r = $fscanf(fd, "%s", tok);
        if (r != 1) begin
          break;
        end
        if (tok == "#") begin
          r = $fgets(rest, fd); // comment to end of line
        end else if (tok == "frame") begin
          r = $fscanf(fd, "%h %h %h %d", f_dst[n_frames], f_src[n_frames],
                      f_type[n_frames], f_len[n_frames]);
          f_base[n_frames] = nb;
          for (int i = 0; i < f_len[n_frames]; i++) begin
            r = $fscanf(fd, "%h", pay_mem[nb]);
            nb++;
          end
          r = $fscanf(fd, "%d %d %h", f_bad[n_frames], f_runt[n_frames], f_exp[n_frames]);
          n_frames++;
        end else if (tok == "totals") begin
          r = $fscanf(fd, "%d %d %d", tot_good, tot_fcs, tot_filt);
        end
      end
      $fclose(fd);
    end
  endtask

  // expected results straight from the filter and fcs rules
  task automatic predict_frame(input int idx);
    rx_status_t st;
    bit         acc;
    int         n;
    acc = !f_runt[idx] && ((f_dst[idx] == STATION) || (f_dst[idx] == 48'hFFFF_FFFF_FFFF));
    st  = '{fcs_ok: !f_runt[idx] && !f_bad[idx], runt: f_runt[idx], accepted: acc};
    check_val($sformatf("frame %0d stim status", idx), f_exp[idx], st);
    exp_stats.push_back(st);
    if (acc) begin
      exp_hdrs.push_back({f_dst[idx], f_src[idx], f_type[idx]});
      n = f_len[idx];
      for (int i = 0; i < n; i++) begin
        exp_bytes.push_back({8'(idx), (i == 0), (i == n - 1), pay_mem[f_base[idx] + i]});
      end
    end
    if (!acc) begin
      tally_filt++;
    end else if (st.fcs_ok) begin
      tally_good++;
    end else begin
      tally_fcs++;
    end
  endtask

  task automatic send_frame(input int idx);
    logic [7:0]   bytes [$];
    logic [31:0]  crc;
    logic [31:0]  fcs;
    logic [111:0] h;
    logic [7:0]   b;
    h   = {f_dst[idx], f_src[idx], f_type[idx]};
    crc = '1;
    for (int i = 0; i < 14; i++) begin
      b = h[111 - 8*i -: 8];
      bytes.push_back(b);
      crc = fcs_step(crc, b);
    end
    for (int i = 0; i < f_len[idx]; i++) begin
      b = pay_mem[f_base[idx] + i];
      bytes.push_back(b);
      crc = fcs_step(crc, b);
    end
    fcs = ~crc;
    for (int i = 0; i < 4; i++) begin
      b = fcs[8*i +: 8];
      if (f_bad[idx] && (i == 1)) begin
        b = b ^ 8'h40; // one flipped bit
      end
      bytes.push_back(b);
    end
    if (f_runt[idx]) begin
      while (bytes.size() > RUNT_KEEP) begin
        void'(bytes.pop_back());
      end
    end
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      phy_val = 1'b1;
      phy_dat = (i == 7) ? SFD_BYTE : PREAMBLE_BYTE;
    end
    foreach (bytes[i]) begin
      @(negedge clk);
      phy_dat = bytes[i];
    end
    @(negedge clk);
    phy_val = 1'b0;
    phy_dat = 8'h00;
    repeat (f_gap[idx] - 1) @(negedge clk);
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!fsm_rst) begin
      if (out_strm.val) begin
        assert (exp_bytes.size() != 0) else begin
          errors++;
          $display("stream byte %0h came out with no payload expected", out_strm.dat);
        end
        if (exp_bytes.size() != 0) begin
          exp_b = exp_bytes.pop_front();
          check_val($sformatf("frame %0d payload", exp_b[17:10]), exp_b[9:0],
                    {out_strm.sof, out_strm.eof, out_strm.dat});
        end
      end
      if (out_hdr_val) begin
        assert (exp_hdrs.size() != 0) else begin
          errors++;
          $display("header strobe from a frame that should be dropped");
        end
        if (exp_hdrs.size() != 0) begin
          check_val("header", exp_hdrs.pop_front(), out_hdr);
        end
      end
      if (frame_done) begin
        assert (exp_stats.size() != 0) else begin
          errors++;
          $display("frame_done with no frame outstanding");
        end
        if (exp_stats.size() != 0) begin
          check_val($sformatf("frame %0d status", done_seen), exp_stats.pop_front(),
                    frame_status);
        end
        done_seen++;
      end
    end
  end

  initial begin
    int total;
    seed        = 32'h6a98ebff;
    errors      = 0;
    cycles      = 0;
    cycle_limit = 100000;
    done_seen   = 0;
    n_frames    = 0;
    tally_good  = 0;
    tally_fcs   = 0;
    tally_filt  = 0;
    fsm_rst     = 1'b1;
    phy_val     = 1'b0;
    phy_dat     = 8'h00;
    read_stim(stim_ok);
    if (!stim_ok) begin
      $display("could not open the stim file bench/mac_rx_stim.txt");
      $display("TESTS FAILED");
      $finish;
    end else begin
      total = 5;
      for (int i = 0; i < n_frames; i++) begin
        if ((i % 2) == 1) begin
          f_gap[i] = MIN_GAP; // back to back
        end else begin
          f_gap[i] = MIN_GAP + int'($unsigned($random(seed)) % 8);
        end
        total += 8 + f_gap[i] + (f_runt[i] ? RUNT_KEEP : 18 + f_len[i]);
      end
      cycle_limit = total + 200;
      repeat (5) @(negedge clk);
      fsm_rst = 1'b0;
      for (int i = 0; i < n_frames; i++) begin
        predict_frame(i);
        send_frame(i);
      end
      while (done_seen < n_frames) @(negedge clk);
      repeat (4) @(negedge clk);
      assert (exp_bytes.size() == 0 && exp_hdrs.size() == 0) else begin
        errors++;
        $display("%0d payload bytes and %0d headers never came out", exp_bytes.size(),
                 exp_hdrs.size());
      end
      check_val("stim total good", tot_good, tally_good);
      check_val("stim total fcs errors", tot_fcs, tally_fcs);
      check_val("stim total filtered", tot_filt, tally_filt);
      check_val("cnt_good", tot_good, cnt_good);
      check_val("cnt_fcs_err", tot_fcs, cnt_fcs_err);
      check_val("cnt_filtered", tot_filt, cnt_filtered);
      $display("summary: %0d frames, %0d errors", n_frames, errors);
      if (errors == 0) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

// File: bench/mac_rx_assertions.sv
module mac_rx_assertions (
  input logic                 clk,
  input logic                 fsm_rst,
  input mac_rx_pkg::rx_strm_t out_strm,
  input logic                 out_hdr_val,
  input logic                 frame_done
);

  // one status word per frame
  done_single: assert property (@(posedge clk) disable iff (fsm_rst)
    frame_done |=> !frame_done)
    else $error("frame_done high on two cycles in a row");

  sof_with_val: assert property (@(posedge clk) disable iff (fsm_rst)
    out_strm.sof |-> out_strm.val)
    else $error("sof without val");

  // status trails the last byte by one cycle
  eof_then_done: assert property (@(posedge clk) disable iff (fsm_rst)
    out_strm.eof |-> ##[1:2] frame_done)
    else $error("eof not followed by frame_done");

  quiet_in_reset: assert property (@(posedge clk)
    fsm_rst |=> (!out_strm.val && !out_hdr_val && !frame_done))
    else $error("output valid during reset");

endmodule

bind mac_rx_top mac_rx_assertions u_mac_rx_assertions (
  .clk         (clk),
  .fsm_rst     (fsm_rst),
  .out_strm    (out_strm),
  .out_hdr_val (out_hdr_val),
  .frame_done  (frame_done)
);

// File: hw/mac_rx_top.sv
module mac_rx_top #(
  parameter mac_rx_pkg::mac_addr_t MAC_ADDR = 48'h02_00_00_00_00_01,
  parameter bit                    PROMISC  = 1'b0
) (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic [7:0]             phy_dat,
  input  logic                   phy_val,
  output mac_rx_pkg::rx_strm_t   out_strm,
  output mac_rx_pkg::mac_hdr_t   out_hdr,
  output logic                   out_hdr_val,
  output logic                   frame_done,
  output mac_rx_pkg::rx_status_t frame_status,
  output mac_rx_pkg::rx_cnt_t    cnt_good,
  output mac_rx_pkg::rx_cnt_t    cnt_fcs_err,
  output mac_rx_pkg::rx_cnt_t    cnt_filtered
);

  import mac_rx_pkg::*;

  // parser to filter
  mac_hdr_t   hdr;
  logic       hdr_val;
  rx_strm_t   strm;
  logic       done;
  rx_status_t status;   // accepted still 0 here

  mac_rx u_mac_rx (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .phy_dat (phy_dat),
    .phy_val (phy_val),
    .hdr     (hdr),
    .hdr_val (hdr_val),
    .strm    (strm),
    .done    (done),
    .status  (status)
  );

  mac_addr_filter #(
    .MAC_ADDR (MAC_ADDR),
    .PROMISC  (PROMISC)
  ) u_mac_addr_filter (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .hdr          (hdr),
    .hdr_val      (hdr_val),
    .strm         (strm),
    .done         (done),
    .status       (status),
    .out_strm     (out_strm),
    .out_hdr      (out_hdr),
    .out_hdr_val  (out_hdr_val),
    .frame_done   (frame_done),
    .frame_status (frame_status),
    .cnt_good     (cnt_good),
    .cnt_fcs_err  (cnt_fcs_err),
    .cnt_filtered (cnt_filtered)
  );

endmodule

// File: hw/mac_addr_filter.sv
module mac_addr_filter #(
  parameter mac_rx_pkg::mac_addr_t MAC_ADDR = 48'h02_00_00_00_00_01,
  parameter bit                    PROMISC  = 1'b0
) (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  mac_rx_pkg::mac_hdr_t   hdr,
  input  logic                   hdr_val,
  input  mac_rx_pkg::rx_strm_t   strm,
  input  logic                   done,
  input  mac_rx_pkg::rx_status_t status,
  output mac_rx_pkg::rx_strm_t   out_strm,
  output mac_rx_pkg::mac_hdr_t   out_hdr,
  output logic                   out_hdr_val,
  output logic                   frame_done,
  output mac_rx_pkg::rx_status_t frame_status,
  output mac_rx_pkg::rx_cnt_t    cnt_good,
  output mac_rx_pkg::rx_cnt_t    cnt_fcs_err,
  output mac_rx_pkg::rx_cnt_t    cnt_filtered
);

  import mac_rx_pkg::*;

  logic match;     // live decision on the header
  logic accept;    // held until the frame ends
  logic frame_acc; // final verdict at done

  assign match = PROMISC || (hdr.dst_mac == MAC_ADDR) || (hdr.dst_mac == MAC_BROADCAST);

  // no header means accept never got set
  assign frame_acc = accept && !status.runt;

  function automatic rx_cnt_t sat_inc(input rx_cnt_t c);
    return (c == '1) ? c : c + rx_cnt_t'(1);
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      accept       <= 1'b0;
      out_hdr_val  <= 1'b0;
      out_strm.val <= 1'b0;
      out_strm.sof <= 1'b0;
      out_strm.eof <= 1'b0;
      frame_done   <= 1'b0;
      cnt_good     <= '0;
      cnt_fcs_err  <= '0;
      cnt_filtered <= '0;
    end else begin
      if (hdr_val) begin
        accept <= match;
      end else if (done) begin
        accept <= 1'b0; // ready for the next frame
      end

      out_hdr      <= hdr;
      out_hdr_val  <= hdr_val && match;
      out_strm.dat <= strm.dat;
      out_strm.val <= strm.val && accept;
      out_strm.sof <= strm.sof && accept;
      out_strm.eof <= strm.eof && accept;

      // status goes out for every frame, dropped or not
      frame_done   <= done;
      frame_status <= '{fcs_ok: status.fcs_ok, runt: status.runt, accepted: frame_acc};

      if (done) begin
        if (!frame_acc) begin
          cnt_filtered <= sat_inc(cnt_filtered);
        end else if (status.fcs_ok) begin
          cnt_good <= sat_inc(cnt_good);
        end else begin
          cnt_fcs_err <= sat_inc(cnt_fcs_err);
        end
      end
    end
  end

endmodule

// File: hw/mac_rx.sv
module mac_rx (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic [7:0]             phy_dat,
  input  logic                   phy_val,
  output mac_rx_pkg::mac_hdr_t   hdr,
  output logic                   hdr_val,
  output mac_rx_pkg::rx_strm_t   strm,
  output logic                   done,
  output mac_rx_pkg::rx_status_t status
);

  import mac_rx_pkg::*;

  typedef enum logic [2:0] {
    idle,
    preamble,
    header,
    payload,
    finish
  } state_t;

  localparam logic [15:0] LAST_HDR_IDX = 16'(MAC_HDR_LEN - 1);
  localparam logic [15:0] MIN_LEN      = 16'(MAC_HDR_LEN + FCS_LEN);

  state_t          state;
  logic [15:0]     byte_cnt;  // bytes since the sfd
  logic [3:0][7:0] hold;      // keeps the last four bytes off the stream
  logic [7:0]      strm_dat;
  logic            strm_val;
  logic            strm_sof;
  logic            sfd_hit;
  logic            in_frame;
  logic            crc_en;
  logic            crc_ok;
  logic            runt;

  // sfd search only while no frame is running
  assign sfd_hit  = phy_val && (phy_dat == SFD_BYTE) &&
                    ((state == idle) || (state == preamble));
  assign in_frame = (state == header) || (state == payload);
  assign crc_en   = in_frame && phy_val;
  assign runt     = (byte_cnt < MIN_LEN);

  crc32 u_crc32 (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clr     (sfd_hit),
    .dat     (phy_dat),
    .val     (crc_en),
    .crc_ok  (crc_ok)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= idle;
      byte_cnt <= '0;
      hdr_val  <= 1'b0;
      strm_val <= 1'b0;
      strm_sof <= 1'b0;
      done     <= 1'b0;
    end else begin
      hdr_val  <= 1'b0;
      strm_val <= 1'b0;
      strm_sof <= 1'b0;
      done     <= 1'b0;

      if (sfd_hit) begin
        byte_cnt <= '0;
      end else if (crc_en && (byte_cnt != '1)) begin
        byte_cnt <= byte_cnt + 16'd1;
      end

      case (state)
        idle: begin
          if (sfd_hit) begin
            state <= header; // no preamble seen, take it anyway
          end else if (phy_val && (phy_dat == PREAMBLE_BYTE)) begin
            state <= preamble;
          end
        end
        preamble: begin
          if (!phy_val) begin
            state <= idle; // ended without sfd, nothing to report
          end else if (sfd_hit) begin
            state <= header;
          end
        end
        header: begin
          if (!phy_val) begin
            state <= finish;
            done  <= 1'b1; // cut short, reported as runt
          end else if (byte_cnt == LAST_HDR_IDX) begin
            hdr_val <= 1'b1;
            state   <= payload;
          end
        end
        payload: begin
          if (!phy_val) begin
            state <= finish;
            done  <= 1'b1;
          end else if (byte_cnt >= MIN_LEN) begin
            // oldest byte in the holding line is payload by now
            strm_val <= 1'b1;
            strm_sof <= (byte_cnt == MIN_LEN);
          end
        end
        finish: begin
          state <= idle; // one dead cycle after done
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (crc_en) begin
      hold <= {hold[2:0], phy_dat};
    end
    if ((state == header) && phy_val) begin
      hdr <= {hdr[$bits(mac_hdr_t)-9:0], phy_dat}; // first byte ends up in dst_mac[5]
    end
    strm_dat <= hold[3];
    // crc register already holds the last fcs byte here
    if (in_frame && !phy_val) begin
      status <= '{fcs_ok: crc_ok && !runt, runt: runt, accepted: 1'b0};
    end
  end

  // the byte on the stream when phy_val drops is the last payload byte
  assign strm = '{dat: strm_dat, val: strm_val, sof: strm_sof, eof: strm_val && !phy_val};

endmodule

// File: hw/crc32.sv
module crc32 (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       clr,
  input  logic [7:0] dat,
  input  logic       val,
  output logic       crc_ok
);

  import mac_rx_pkg::*;

  localparam logic [31:0] POLY = 32'h04C11DB7; // ieee 802.3

  logic [31:0] crc;

  // one octet per call, bit 0 first as on the wire
  function automatic logic [31:0] crc_byte(
    input logic [31:0] c,
    input logic [7:0]  d
  );
    logic [31:0] r;
    logic        fb;
    r = c;
    for (int i = 0; i < 8; i++) begin
      fb = r[31] ^ d[i];
      r  = {r[30:0], 1'b0};
      if (fb) begin
        r = r ^ POLY;
      end
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst || clr) begin
      crc <= '1; // preset
    end else if (val) begin
      crc <= crc_byte(crc, dat);
    end
  end

  // fcs bytes included, so a clean frame lands on the fixed residue
  assign crc_ok = (crc == CRC_RESIDUE);

endmodule

// File: hw/mac_rx_pkg.sv
package mac_rx_pkg;

  // six octets, [5] is the first one on the wire
  typedef logic [5:0][7:0] mac_addr_t;

  // header in wire order, dst first
  typedef struct packed {
    mac_addr_t   dst_mac;
    mac_addr_t   src_mac;
    logic [15:0] ethertype; // network order, byte 12 in the upper half
  } mac_hdr_t;

  // payload byte stream, fcs already stripped
  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof; // first payload byte
    logic       eof; // last payload byte
  } rx_strm_t;

  // one word per frame, valid with the done strobe
  typedef struct packed {
    logic fcs_ok;
    logic runt;     // fewer than hdr + fcs bytes after the sfd
    logic accepted; // set by the address filter
  } rx_status_t;

  typedef logic [15:0] rx_cnt_t; // saturates at all ones

  // frame layout
  localparam int unsigned MAC_HDR_LEN = 14;
  localparam int unsigned FCS_LEN     = 4;

  // bytes ahead of the header
  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0] SFD_BYTE      = 8'hD5;

  // crc register after a frame with a good fcs has been folded in
  // (msb-first register, data fed lsb first)
  localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

  localparam mac_addr_t MAC_BROADCAST = '1;

endpackage
